// File: include/island_macros.svh
// Safety island constants
// Address map, bus widths and reset values shared by the design

`ifndef ISL_MACROS_SVH
`define ISL_MACROS_SVH

// ------------------------------------------------------------
// Widths
// ------------------------------------------------------------
`define ISL_ADDR_W 32
`define ISL_DATA_W 32
`define ISL_ECC_W 39
`define ISL_MEM_WORDS 1024

// ------------------------------------------------------------
// Address map
// ------------------------------------------------------------
`define ISL_MEM_BASE 32'h0000_0000
`define ISL_PERIPH_BASE 32'h0002_0000

// Peripheral slots, 256 bytes each
`define ISL_SOC_CTRL_IDX 2'd0
`define ISL_ECC_MGR_IDX 2'd1
`define ISL_TIMER_IDX 2'd2

`define ISL_ERR_RDATA 32'hBADC_AB1E
`define ISL_BOOT_ADDR_DEFAULT (`ISL_PERIPH_BASE + 32'h80)

`endif

// File: project.f
+incdir+include
rtl/island_pkg.sv
rtl/island_bus_if.sv
rtl/island_apb_decoder.sv
rtl/ecc_sram_bank.sv
rtl/ecc_manager.sv
rtl/soc_ctrl_regs.sv
rtl/apb_timer.sv
rtl/island_top.sv
test/island_sva.sv
test/island_tb.sv

// File: rtl/apb_timer.sv
// Compare timer
// Counts while enabled, wraps on compare match and latches a
// pending interrupt until software clears it

`include "island_macros.svh"

module apb_timer (
  input  logic      clk_i,
  input  logic      rst_ni,
  island_bus_if.sub bus_i,
  output logic      irq_o
);

  logic [`ISL_DATA_W-1:0] count_q, cmp_q;
  logic                   enable_q;
  logic                   pending_q;
  logic [5:0]             idx;
  logic                   wr_acc;

  assign idx    = bus_i.paddr.periph_view.reg_idx;
  assign wr_acc = bus_i.psel && bus_i.penable && bus_i.pwrite;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      enable_q  <= 1'b0;
      count_q   <= '0;
      cmp_q     <= '0;
      pending_q <= 1'b0;
    end else begin
      if (wr_acc && idx == 6'd0) begin
        enable_q <= bus_i.pwdata[0];
      end
      if (wr_acc && idx == 6'd2) begin
        cmp_q <= bus_i.pwdata;
      end

      // Bus writes take priority over counting
      if (wr_acc && idx == 6'd0 && bus_i.pwdata[1]) begin
        count_q <= '0;
      end else if (wr_acc && idx == 6'd1) begin
        count_q <= bus_i.pwdata;
      end else if (enable_q) begin
        count_q <= (count_q == cmp_q) ? '0 : count_q + 1'b1;
      end

      if (wr_acc && idx == 6'd3) begin
        pending_q <= 1'b0;
      end else if (enable_q && count_q == cmp_q) begin
        pending_q <= 1'b1;
      end
    end
  end

  always_comb begin
    case (idx)
      6'd0:    bus_i.prdata = {{(`ISL_DATA_W-1){1'b0}}, enable_q};
      6'd1:    bus_i.prdata = count_q;
      6'd2:    bus_i.prdata = cmp_q;
      6'd3:    bus_i.prdata = {{(`ISL_DATA_W-1){1'b0}}, pending_q};
      default: bus_i.prdata = '0;
    endcase
  end

  assign bus_i.pready  = 1'b1;
  assign bus_i.pslverr = 1'b0;
  assign irq_o         = pending_q;

endmodule

// File: rtl/ecc_manager.sv
// ECC manager
// Saturating error counters and the fault injection mask

`include "island_macros.svh"

module ecc_manager (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  island_bus_if.sub             bus_i,
  input  logic                  single_err_i,
  input  logic                  double_err_i,
  input  logic                  inject_used_i,
  output logic [`ISL_ECC_W-1:0] inject_mask_o
);

  logic [`ISL_DATA_W-1:0] corr_q, unc_q;
  island_pkg::ecc_word_t  mask_q;
  logic [5:0]             idx;
  logic                   wr_acc;

  assign idx    = bus_i.paddr.periph_view.reg_idx;
  assign wr_acc = bus_i.psel && bus_i.penable && bus_i.pwrite;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      corr_q <= '0;
      unc_q  <= '0;
      mask_q <= '0;
    end else begin
      if (wr_acc && idx == 6'd0) begin
        corr_q <= '0;
      end else if (single_err_i && corr_q != '1) begin
        corr_q <= corr_q + 1'b1;
      end
      if (wr_acc && idx == 6'd1) begin
        unc_q <= '0;
      end else if (double_err_i && unc_q != '1) begin
        unc_q <= unc_q + 1'b1;
      end
      // Mask is one-shot, gone once a write has used it
      if (inject_used_i) begin
        mask_q <= '0;
      end else if (wr_acc && idx == 6'd2) begin
        mask_q.data <= bus_i.pwdata;
      end else if (wr_acc && idx == 6'd3) begin
        mask_q.chk <= bus_i.pwdata[`ISL_ECC_W-`ISL_DATA_W-1:0];
      end
    end
  end

  always_comb begin
    case (idx)
      6'd0:    bus_i.prdata = corr_q;
      6'd1:    bus_i.prdata = unc_q;
      6'd2:    bus_i.prdata = mask_q.data;
      6'd3:    bus_i.prdata = {{(2*`ISL_DATA_W-`ISL_ECC_W){1'b0}}, mask_q.chk};
      default: bus_i.prdata = '0;
    endcase
  end

  assign bus_i.pready  = 1'b1;
  assign bus_i.pslverr = 1'b0;
  assign inject_mask_o = mask_q;

endmodule

// File: rtl/ecc_sram_bank.sv
// SECDED protected SRAM bank (Hamming 39/32)
// Encodes on write with optional fault injection, reads on the setup
// edge and corrects single errors in the access phase

`include "island_macros.svh"

module ecc_sram_bank (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  island_bus_if.sub             bus_i,
  input  logic [`ISL_ECC_W-1:0] inject_mask_i,
  output logic                  inject_used_o,
  output logic                  single_err_o,
  output logic                  double_err_o
);

  // Hamming checks over codeword positions 1..38, powers of two hold checks
  function automatic logic [5:0] hamming_chk(logic [`ISL_DATA_W-1:0] d);
    logic [5:0]  c;
    int unsigned di;
    c  = '0;
    di = 0;
    for (int p = 1; p < 39; p++) begin
      if ((p & (p - 1)) != 0) begin
        for (int i = 0; i < 6; i++) begin
          if (p[i]) begin
            c[i] = c[i] ^ d[di];
          end
        end
        di++;
      end
    end
    return c;
  endfunction

  // Data bit sitting at codeword position s
  function automatic logic [`ISL_DATA_W-1:0] flip_mask(logic [5:0] s);
    logic [`ISL_DATA_W-1:0] m;
    int unsigned            di;
    m  = '0;
    di = 0;
    for (int p = 1; p < 39; p++) begin
      if ((p & (p - 1)) != 0) begin
        if (p == int'(s)) begin
          m[di] = 1'b1;
        end
        di++;
      end
    end
    return m;
  endfunction

  island_pkg::ecc_word_t mem_q [`ISL_MEM_WORDS];
  island_pkg::ecc_word_t rd_q;
  island_pkg::ecc_word_t wr_word;
  logic [5:0] wr_chk;
  logic [5:0] syndrome;
  logic       rd_vld_q;
  logic       rd_setup, rd_acc, wr_acc;
  logic       parity_err;

  assign rd_setup = bus_i.psel && !bus_i.penable && !bus_i.pwrite;
  assign rd_acc   = bus_i.psel && bus_i.penable && rd_vld_q;
  assign wr_acc   = bus_i.psel && bus_i.penable && bus_i.pwrite;

  // ------------------------------------------------------------
  // Encode and store
  // ------------------------------------------------------------
  assign wr_chk  = hamming_chk(bus_i.pwdata);
  assign wr_word = {^{wr_chk, bus_i.pwdata}, wr_chk, bus_i.pwdata} ^ inject_mask_i;
  assign inject_used_o = wr_acc && (|inject_mask_i);

  always_ff @(posedge clk_i) begin
    if (wr_acc) begin
      mem_q[bus_i.paddr.mem_view.word] <= wr_word;
    end
    if (rd_setup) begin
      rd_q <= mem_q[bus_i.paddr.mem_view.word];
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_vld_q <= 1'b0;
    end else begin
      rd_vld_q <= rd_setup;
    end
  end

  // ------------------------------------------------------------
  // Decode and correct
  // ------------------------------------------------------------
  assign syndrome   = hamming_chk(rd_q.data) ^ rd_q.chk[5:0];
  assign parity_err = ^rd_q;

  // Odd parity flip means one bit, even parity with a syndrome means two
  assign single_err_o = rd_acc && parity_err;
  assign double_err_o = rd_acc && !parity_err && (syndrome != '0);

  assign bus_i.prdata  = parity_err ? (rd_q.data ^ flip_mask(syndrome)) : rd_q.data;
  assign bus_i.pslverr = double_err_o;
  assign bus_i.pready  = 1'b1;

endmodule

// File: rtl/island_apb_decoder.sv
// APB address decoder
// Selects the memory or one peripheral slot; unmapped addresses
// complete on an internal error subordinate

`include "island_macros.svh"

module island_apb_decoder (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    psel_i,
  input  logic                    penable_i,
  input  logic                    pwrite_i,
  input  logic [`ISL_ADDR_W-1:0]  paddr_i,
  input  logic [`ISL_DATA_W-1:0]  pwdata_i,
  output logic [`ISL_DATA_W-1:0]  prdata_o,
  output logic                    pready_o,
  output logic                    pslverr_o,
  island_bus_if.mgr               mem_o,
  island_bus_if.mgr               soc_o,
  island_bus_if.mgr               ecc_o,
  island_bus_if.mgr               tmr_o
);

  localparam island_pkg::island_addr_u MemBase    = `ISL_MEM_BASE;
  localparam island_pkg::island_addr_u PeriphBase = `ISL_PERIPH_BASE;

  island_pkg::island_addr_u addr;
  logic mem_hit, periph_hit, soc_hit, ecc_hit, tmr_hit, err_hit;
  logic err_q;

  assign addr = paddr_i;

  assign mem_hit    = addr.mem_view.region == MemBase.mem_view.region;
  assign periph_hit = addr.periph_view.region == PeriphBase.periph_view.region;
  assign soc_hit    = periph_hit && (addr.periph_view.slot == `ISL_SOC_CTRL_IDX);
  assign ecc_hit    = periph_hit && (addr.periph_view.slot == `ISL_ECC_MGR_IDX);
  assign tmr_hit    = periph_hit && (addr.periph_view.slot == `ISL_TIMER_IDX);
  assign err_hit    = !(mem_hit || soc_hit || ecc_hit || tmr_hit);

  // ------------------------------------------------------------
  // Request fan-out
  // ------------------------------------------------------------
  assign mem_o.psel = psel_i && mem_hit;
  assign soc_o.psel = psel_i && soc_hit;
  assign ecc_o.psel = psel_i && ecc_hit;
  assign tmr_o.psel = psel_i && tmr_hit;

  assign {mem_o.penable, soc_o.penable, ecc_o.penable, tmr_o.penable} = {4{penable_i}};
  assign {mem_o.pwrite, soc_o.pwrite, ecc_o.pwrite, tmr_o.pwrite} = {4{pwrite_i}};
  assign {mem_o.paddr, soc_o.paddr, ecc_o.paddr, tmr_o.paddr} = {4{addr}};
  assign {mem_o.pwdata, soc_o.pwdata, ecc_o.pwdata, tmr_o.pwdata} = {4{pwdata_i}};

  // Error subordinate owns the access phase after an unmapped setup
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      err_q <= 1'b0;
    end else begin
      err_q <= psel_i && !penable_i && err_hit;
    end
  end

  // ------------------------------------------------------------
  // Response mux
  // ------------------------------------------------------------
  always_comb begin
    prdata_o  = '0;
    pslverr_o = 1'b0;
    pready_o  = 1'b1;
    if (psel_i && penable_i) begin
      if (err_q) begin
        prdata_o  = `ISL_ERR_RDATA;
        pslverr_o = 1'b1;
      end else if (mem_hit) begin
        prdata_o  = mem_o.prdata;
        pslverr_o = mem_o.pslverr;
        pready_o  = mem_o.pready;
      end else if (soc_hit) begin
        prdata_o  = soc_o.prdata;
        pslverr_o = soc_o.pslverr;
        pready_o  = soc_o.pready;
      end else if (ecc_hit) begin
        prdata_o  = ecc_o.prdata;
        pslverr_o = ecc_o.pslverr;
        pready_o  = ecc_o.pready;
      end else if (tmr_hit) begin
        prdata_o  = tmr_o.prdata;
        pslverr_o = tmr_o.pslverr;
        pready_o  = tmr_o.pready;
      end
    end
  end

endmodule

// File: rtl/island_bus_if.sv
// APB link between the decoder and one subordinate

`include "island_macros.svh"

interface island_bus_if;

  logic                      psel;
  logic                      penable;
  logic                      pwrite;
  island_pkg::island_addr_u  paddr;
  logic [`ISL_DATA_W-1:0]    pwdata;
  logic [`ISL_DATA_W-1:0]    prdata;
  logic                      pready;
  logic                      pslverr;

  modport mgr (
    output psel, penable, pwrite, paddr, pwdata,
    input  prdata, pready, pslverr
  );

  modport sub (
    input  psel, penable, pwrite, paddr, pwdata,
    output prdata, pready, pslverr
  );

endinterface

// File: rtl/island_pkg.sv
// Safety island types
// Boot mode encoding, address views and the SECDED codeword

`include "island_macros.svh"

package island_pkg;

  typedef enum logic [1:0] {
    BOOT_JTAG      = 2'd0,
    BOOT_SPI       = 2'd1,
    BOOT_PRELOADED = 2'd2
  } bootmode_e;

  // Same bus address, seen by the memory or by a peripheral slot
  typedef union packed {
    struct packed {
      logic [19:0] region;
      logic [9:0]  word;
      logic [1:0]  byte_off;
    } mem_view;
    struct packed {
      logic [21:0] region;
      logic [1:0]  slot;
      logic [5:0]  reg_idx;
      logic [1:0]  byte_off;
    } periph_view;
  } island_addr_u;

  // chk[5:0] Hamming checks, chk[6] overall parity
  typedef struct packed {
    logic [`ISL_ECC_W-`ISL_DATA_W-1:0] chk;
    logic [`ISL_DATA_W-1:0]            data;
  } ecc_word_t;

endpackage

// File: rtl/island_top.sv
// Safety island top level
// One APB port into an ECC protected bank and three peripherals

`include "island_macros.svh"

module island_top (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    psel_i,
  input  logic                    penable_i,
  input  logic                    pwrite_i,
  input  logic [`ISL_ADDR_W-1:0]  paddr_i,
  input  logic [`ISL_DATA_W-1:0]  pwdata_i,
  output logic [`ISL_DATA_W-1:0]  prdata_o,
  output logic                    pready_o,
  output logic                    pslverr_o,
  input  island_pkg::bootmode_e   bootmode_i,
  input  logic                    fetch_enable_i,
  output logic                    fetch_enable_o,
  output logic [`ISL_ADDR_W-1:0]  boot_addr_o,
  output logic                    irq_o
);

  island_bus_if mem_bus ();
  island_bus_if soc_bus ();
  island_bus_if ecc_bus ();
  island_bus_if tmr_bus ();

  logic [`ISL_ECC_W-1:0] inject_mask;
  logic                  inject_used;
  logic                  single_err;
  logic                  double_err;

  island_apb_decoder i_decoder (
    .clk_i,
    .rst_ni,
    .psel_i,
    .penable_i,
    .pwrite_i,
    .paddr_i,
    .pwdata_i,
    .prdata_o,
    .pready_o,
    .pslverr_o,
    .mem_o     ( mem_bus ),
    .soc_o     ( soc_bus ),
    .ecc_o     ( ecc_bus ),
    .tmr_o     ( tmr_bus )
  );

  ecc_sram_bank i_bank (
    .clk_i,
    .rst_ni,
    .bus_i         ( mem_bus     ),
    .inject_mask_i ( inject_mask ),
    .inject_used_o ( inject_used ),
    .single_err_o  ( single_err  ),
    .double_err_o  ( double_err  )
  );

  ecc_manager i_ecc_mgr (
    .clk_i,
    .rst_ni,
    .bus_i         ( ecc_bus     ),
    .single_err_i  ( single_err  ),
    .double_err_i  ( double_err  ),
    .inject_used_i ( inject_used ),
    .inject_mask_o ( inject_mask )
  );

  soc_ctrl_regs i_soc_ctrl (
    .clk_i,
    .rst_ni,
    .bus_i ( soc_bus ),
    .bootmode_i,
    .fetch_enable_i,
    .fetch_enable_o,
    .boot_addr_o
  );

  apb_timer i_timer (
    .clk_i,
    .rst_ni,
    .bus_i ( tmr_bus ),
    .irq_o
  );

endmodule

// File: rtl/soc_ctrl_regs.sv
// SoC control registers
// Boot address, fetch enable and the boot mode captured after reset

`include "island_macros.svh"

module soc_ctrl_regs (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  island_bus_if.sub               bus_i,
  input  island_pkg::bootmode_e   bootmode_i,
  input  logic                    fetch_enable_i,
  output logic                    fetch_enable_o,
  output logic [`ISL_ADDR_W-1:0]  boot_addr_o
);

  logic [`ISL_ADDR_W-1:0] boot_addr_q;
  island_pkg::bootmode_e  bootmode_q;
  logic                   fetchen_q;
  logic                   first_q;
  logic [5:0]             idx;
  logic                   wr_acc;

  assign idx    = bus_i.paddr.periph_view.reg_idx;
  assign wr_acc = bus_i.psel && bus_i.penable && bus_i.pwrite;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      first_q     <= 1'b1;
      boot_addr_q <= `ISL_BOOT_ADDR_DEFAULT;
      bootmode_q  <= island_pkg::BOOT_JTAG;
      fetchen_q   <= 1'b0;
    end else begin
      first_q <= 1'b0;
      // Sample the pins once, in the first cycle out of reset
      if (first_q) begin
        bootmode_q <= bootmode_i;
        fetchen_q  <= bootmode_i == island_pkg::BOOT_JTAG;
      end else if (wr_acc && idx == 6'd1) begin
        fetchen_q <= bus_i.pwdata[0];
      end
      if (wr_acc && idx == 6'd0) begin
        boot_addr_q <= bus_i.pwdata;
      end
    end
  end

  always_comb begin
    case (idx)
      6'd0:    bus_i.prdata = boot_addr_q;
      6'd1:    bus_i.prdata = {{(`ISL_DATA_W-1){1'b0}}, fetchen_q};
      6'd2:    bus_i.prdata = {{(`ISL_DATA_W-2){1'b0}}, bootmode_q};
      default: bus_i.prdata = '0;
    endcase
  end

  assign bus_i.pready   = 1'b1;
  assign bus_i.pslverr  = 1'b0;
  assign fetch_enable_o = fetchen_q || fetch_enable_i;
  assign boot_addr_o    = boot_addr_q;

endmodule

// File: run.sh
#!/bin/sh
# Build the safety island testbench with Verilator and run it
verilator --binary --timing --assert -Wno-fatal -f project.f \
  --top-module island_tb -o island_sim || exit 1
out=$(./obj_dir/island_sim)
echo "$out"
echo "$out" | grep -q "^NO ERRORS$" && exit 0 || exit 1

// File: test/island_sva.sv
// APB protocol checks on the host side of the island decoder

module island_sva (
  input logic clk_i,
  input logic rst_ni,
  input logic psel_i,
  input logic penable_i,
  input logic pready_o,
  input logic pslverr_o
);

  timeunit 1ns;
  timeprecision 1ps;

  // No subordinate in the island inserts wait states
  ready_in_access: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    psel_i && penable_i |-> pready_o
  ) else $error("pready low during an APB access phase");

  err_with_ready: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    pslverr_o |-> pready_o
  ) else $error("pslverr high without pready");

  // Access phase must directly follow a setup phase
  enable_after_setup: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    $rose(penable_i) |-> psel_i && $past(psel_i && !penable_i)
  ) else $error("penable rose without a preceding setup phase");

endmodule

bind island_apb_decoder island_sva i_apb_sva (
  .clk_i,
  .rst_ni,
  .psel_i,
  .penable_i,
  .pready_o,
  .pslverr_o
);

// File: test/island_tb.sv
// Safety island testbench
// Random APB traffic checked against a model of the memory, the ECC
// counters, the boot registers and the timer interrupt

`include "island_macros.svh"

module island_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam logic [31:0] LfsrTaps = 32'h8020_0003;
  localparam logic [31:0] SocBase  = `ISL_PERIPH_BASE;
  localparam logic [31:0] EccBase  = `ISL_PERIPH_BASE + 32'h100;
  localparam logic [31:0] TmrBase  = `ISL_PERIPH_BASE + 32'h200;
  localparam int NumRandOps  = 240;
  localparam int NumInject   = 8;
  localparam int NumUnmapped = 24;
  localparam int MaxCompare  = 39;
  localparam int NumXfers    = NumRandOps + 15 * NumInject + 4 * NumUnmapped + 12;
  localparam int MaxCycles   = 3 * NumXfers + 2 * (MaxCompare + 4) + 50;

  logic                  clk = 1'b0;
  logic                  rst_n;
  logic                  psel, penable, pwrite;
  logic [31:0]           paddr, pwdata, prdata;
  logic                  pready, pslverr;
  island_pkg::bootmode_e bootmode;
  logic                  fetch_en_in, fetch_en_out;
  logic [31:0]           boot_addr;
  logic                  irq;

  // Reference model
  logic [31:0] mem_model [`ISL_MEM_WORDS];
  bit          mem_valid [`ISL_MEM_WORDS];
  logic [9:0]  written_q [$];
  logic [31:0] corr_exp, unc_exp;

  logic [31:0] lfsr_q;
  int unsigned checks, errors;
  int unsigned cycles = 0;
  logic [31:0] rdata, data, addr, cmp;
  logic [38:0] mask;
  logic [9:0]  idx;
  logic        err;
  int unsigned k, waits;

  island_top DUT (
    .clk_i          ( clk          ),
    .rst_ni         ( rst_n        ),
    .psel_i         ( psel         ),
    .penable_i      ( penable      ),
    .pwrite_i       ( pwrite       ),
    .paddr_i        ( paddr        ),
    .pwdata_i       ( pwdata       ),
    .prdata_o       ( prdata       ),
    .pready_o       ( pready       ),
    .pslverr_o      ( pslverr      ),
    .bootmode_i     ( bootmode     ),
    .fetch_enable_i ( fetch_en_in  ),
    .fetch_enable_o ( fetch_en_out ),
    .boot_addr_o    ( boot_addr    ),
    .irq_o          ( irq          )
  );

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MaxCycles) begin
      $display("Timeout: run did not finish within %0d cycles", MaxCycles);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  // ------------------------------------------------------------
  // Helpers
  // ------------------------------------------------------------
  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ LfsrTaps) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] rand_bits(int unsigned n);
    logic [31:0] v;
    v = '0;
    for (int unsigned i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  function automatic logic [31:0] mem_addr(logic [9:0] i);
    return `ISL_MEM_BASE + {20'd0, i, 2'b00};
  endfunction

  function automatic logic is_mapped(logic [31:0] a);
    return (a < `ISL_MEM_BASE + 32'h1000) ||
           (a >= `ISL_PERIPH_BASE && a < `ISL_PERIPH_BASE + 32'h300);
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  // Setup then access with the response sampled mid-cycle once pready is seen
  task automatic apb_xfer(input logic write, input logic [31:0] a, input logic [31:0] wdata,
                          output logic [31:0] rd, output logic e);
    int unsigned w;
    w = 0;
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= write;
    paddr   <= a;
    pwdata  <= wdata;
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk);
    while (pready !== 1'b1 && w < 8) begin
      @(negedge clk);
      w++;
    end
    if (pready !== 1'b1) begin
      errors++;
      $display("pready never rose for the transfer at address %h", a);
    end
    rd = prdata;
    e  = pslverr;
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic store_word(input logic [9:0] i, input logic [31:0] d, input string name);
    logic [31:0] rd;
    logic        e;
    apb_xfer(1'b1, mem_addr(i), d, rd, e);
    check_value({name, " pslverr"}, 32'd0, 32'(e));
    if (!mem_valid[i]) begin
      written_q.push_back(i);
    end
    mem_model[i] = d;
    mem_valid[i] = 1'b1;
  endtask

  task automatic load_word(input logic [9:0] i, input string name);
    logic [31:0] rd;
    logic        e;
    apb_xfer(1'b0, mem_addr(i), 32'd0, rd, e);
    check_value(name, mem_model[i], rd);
    check_value({name, " pslverr"}, 32'd0, 32'(e));
  endtask

  task automatic set_mask(input logic [38:0] m);
    logic [31:0] rd;
    logic        e;
    apb_xfer(1'b1, EccBase + 32'h8, m[31:0], rd, e);
    apb_xfer(1'b1, EccBase + 32'hC, {25'd0, m[38:32]}, rd, e);
  endtask

  task automatic check_mask_clear();
    logic [31:0] rd;
    logic        e;
    apb_xfer(1'b0, EccBase + 32'h8, 32'd0, rd, e);
    check_value("inject mask low", 32'd0, rd);
    apb_xfer(1'b0, EccBase + 32'hC, 32'd0, rd, e);
    check_value("inject mask high", 32'd0, rd);
  endtask

  // ------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------
  initial begin
    lfsr_q   = 32'd6;
    checks   = 0;
    errors   = 0;
    corr_exp = '0;
    unc_exp  = '0;
    rst_n    = 1'b0;
    psel     = 1'b0;
    penable  = 1'b0;
    pwrite   = 1'b0;
    paddr    = '0;
    pwdata   = '0;
    k        = rand_bits(2) % 3;
    bootmode = island_pkg::bootmode_e'(k[1:0]);
    fetch_en_in = rand_bits(1) == 32'd1;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    repeat (3) @(posedge clk);
    @(negedge clk);

    // Reset state and boot control
    check_value("reset prdata", 32'd0, prdata);
    check_value("reset pslverr", 32'd0, 32'(pslverr));
    check_value("reset irq", 32'd0, 32'(irq));
    check_value("reset boot_addr", `ISL_BOOT_ADDR_DEFAULT, boot_addr);
    check_value("fetch_enable_o", 32'(fetch_en_in || bootmode == island_pkg::BOOT_JTAG),
                32'(fetch_en_out));
    // Pin low leaves only the register preset at reset
    @(posedge clk);
    fetch_en_in <= 1'b0;
    @(negedge clk);
    check_value("fetch_enable_o with pin low", 32'(bootmode == island_pkg::BOOT_JTAG),
                32'(fetch_en_out));
    apb_xfer(1'b0, SocBase + 32'h8, 32'd0, rdata, err);
    check_value("bootmode register", 32'(bootmode), rdata);
    data = rand_bits(32) & 32'hFFFF_FFFC;
    apb_xfer(1'b1, SocBase, data, rdata, err);
    @(negedge clk);
    check_value("boot_addr after write", data, boot_addr);
    apb_xfer(1'b0, SocBase, 32'd0, rdata, err);
    check_value("boot address readback", data, rdata);

    // Random memory traffic
    for (int n = 0; n < NumRandOps; n++) begin
      if (written_q.size() == 0 || rand_bits(1) == 32'd1) begin
        store_word(10'(rand_bits(10)), rand_bits(32), "mem write");
      end else begin
        load_word(written_q[rand_bits(16) % written_q.size()], "mem read");
      end
    end

    // Fault injection
    for (int n = 0; n < NumInject; n++) begin
      k    = rand_bits(6) % 39;
      mask = 39'd1 << k;
      set_mask(mask);
      idx  = 10'(rand_bits(10));
      store_word(idx, rand_bits(32), "single inject write");
      check_mask_clear();
      load_word(idx, "corrected read");
      corr_exp = corr_exp + 1;
      apb_xfer(1'b0, EccBase, 32'd0, rdata, err);
      check_value("corrected count", corr_exp, rdata);

      k    = rand_bits(5);
      mask = (39'd1 << k) | (39'd1 << (k + 1 + rand_bits(2)));
      set_mask(mask);
      idx  = 10'(rand_bits(10));
      data = rand_bits(32);
      store_word(idx, data, "double inject write");
      check_mask_clear();
      apb_xfer(1'b0, mem_addr(idx), 32'd0, rdata, err);
      check_value("uncorrectable pslverr", 32'd1, 32'(err));
      unc_exp = unc_exp + 1;
      apb_xfer(1'b0, EccBase + 32'h4, 32'd0, rdata, err);
      check_value("uncorrectable count", unc_exp, rdata);
      // Rewrite the damaged word so later reads see clean data
      store_word(idx, data, "rewrite");
    end

    // Unmapped space at random addresses and in the unused fourth slot
    for (int n = 0; n < NumUnmapped; n++) begin
      if (n % 2 == 0) begin
        addr = rand_bits(32) & 32'hFFFF_FFFC;
        if (is_mapped(addr)) begin
          addr = addr | 32'h8000_0000;
        end
      end else begin
        addr = SocBase + 32'h300 + (rand_bits(8) & 32'hFC);
      end
      // Word the bank would hit if the unmapped write leaked through
      idx = addr[11:2];
      if (!mem_valid[idx]) begin
        store_word(idx, rand_bits(32), "unmapped prefill write");
      end
      apb_xfer(1'b1, addr, rand_bits(32), rdata, err);
      check_value("unmapped write pslverr", 32'd1, 32'(err));
      apb_xfer(1'b0, addr, 32'd0, rdata, err);
      check_value("unmapped read data", `ISL_ERR_RDATA, rdata);
      check_value("unmapped read pslverr", 32'd1, 32'(err));
      load_word(idx, "memory after unmapped write");
    end

    // Timer compare interrupt
    cmp = 8 + rand_bits(5);
    apb_xfer(1'b1, TmrBase + 32'h8, cmp, rdata, err);
    apb_xfer(1'b1, TmrBase, 32'h3, rdata, err);
    for (int n = 0; n < int'(cmp); n++) begin
      @(negedge clk);
      check_value("timer irq before compare", 32'd0, 32'(irq));
    end
    waits = 0;
    while (irq !== 1'b1 && waits < 4) begin
      @(negedge clk);
      waits++;
    end
    check_value("timer irq by compare plus 4", 32'd1, 32'(irq));
    apb_xfer(1'b1, TmrBase, 32'h0, rdata, err);
    apb_xfer(1'b0, TmrBase + 32'hC, 32'd0, rdata, err);
    check_value("timer pending", 32'd1, rdata);
    apb_xfer(1'b1, TmrBase + 32'hC, 32'd1, rdata, err);
    @(negedge clk);
    check_value("timer irq after clear", 32'd0, 32'(irq));

    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule
